// ==== filelist.f ====
hdl/cache_geometry_pkg.sv
hdl/wishbone_pkg.sv
hdl/cache_datapath.sv
hdl/eviction_buffer.sv
hdl/eviction_buffered_cache_controller.sv
hdl/eviction_buffered_cache.sv
testbench/tb_clock_gen.sv
testbench/tb_memory_model.sv
testbench/tb_eviction_buffered_cache.sv

// ==== hdl/cache_datapath.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_datapath
    import cache_geometry_pkg::*;
    import wishbone_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  cpu_req_t            cpu_req,
    input  line_data_t          mem_rdata,
    input  way_idx_t            way_sel,
    input  logic                fill_sel,
    input  logic                tag_bypass_sel,
    input  logic                load,
    input  logic                load_age,
    output logic [num_ways-1:0] hit,
    output logic                dirty,
    output way_idx_t            lru_way,
    output line_data_t          cpu_rdata,
    output line_addr_t          victim_addr,
    output line_data_t          victim_data,
    output line_addr_t          fill_addr
);

    cpu_req_t   req_q;
    line_data_t fill_line_q;

    tag_t       tag_mem  [num_ways][num_sets];
    line_data_t line_mem [num_ways][num_sets];
    logic       valid_q  [num_ways][num_sets];
    logic       dirty_q  [num_ways][num_sets];
    age_t       age_q    [num_ways][num_sets];

    set_idx_t   set_idx;
    tag_t       req_tag;
    line_data_t sel_line;
    line_data_t merged_line;

    // The request is refreshed while the CPU keeps its strobe up, and its fields are stable then
    always_ff @(posedge clk) begin
        if (cpu_req.cyc && cpu_req.stb) begin
            req_q <= cpu_req;
        end
        // Memory read data is only valid in its ack cycle, so keep a copy for the fill write
        fill_line_q <= mem_rdata;
    end

    assign set_idx = req_q.adr[set_bits-1:0];
    assign req_tag = req_q.adr[line_addr_bits-1:set_bits];

    // Tag compare across all ways of the indexed set
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit[w] = valid_q[w][set_idx] && (tag_mem[w][set_idx] == req_tag);
        end
    end

    // The oldest way carries the highest rank
    always_comb begin
        lru_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (age_q[w][set_idx] == age_t'(num_ways - 1)) begin
                lru_way = way_idx_t'(w);
            end
        end
    end

    assign dirty = valid_q[lru_way][set_idx] && dirty_q[lru_way][set_idx];

    assign sel_line    = line_mem[way_sel][set_idx];
    assign cpu_rdata   = sel_line;
    assign victim_data = sel_line;
    assign victim_addr = {tag_mem[way_sel][set_idx], set_idx};
    assign fill_addr   = req_q.adr;

    // CPU write bytes laid over the stored line
    always_comb begin
        merged_line = sel_line;
        for (int b = 0; b < line_bytes; b++) begin
            if (req_q.sel[b]) begin
                merged_line[b*8 +: 8] = req_q.dat[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            line_mem[way_sel][set_idx] <= fill_sel ? fill_line_q : merged_line;
            if (tag_bypass_sel) begin
                tag_mem[way_sel][set_idx] <= req_tag;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int w = 0; w < num_ways; w++) begin
                for (int s = 0; s < num_sets; s++) begin
                    valid_q[w][s] <= 1'b0;
                    dirty_q[w][s] <= 1'b0;
                    age_q[w][s]   <= age_t'(w);
                end
            end
        end else begin
            // A fill leaves the line clean, a CPU write marks it dirty
            if (load) begin
                valid_q[way_sel][set_idx] <= 1'b1;
                dirty_q[way_sel][set_idx] <= !fill_sel;
            end
            // The accessed way becomes youngest and the younger ones age by one
            if (load_age) begin
                for (int w = 0; w < num_ways; w++) begin
                    if (way_idx_t'(w) == way_sel) begin
                        age_q[w][set_idx] <= '0;
                    end else if (age_q[w][set_idx] < age_q[way_sel][set_idx]) begin
                        age_q[w][set_idx] <= age_q[w][set_idx] + 1'b1;
                    end
                end
            end
        end
    end

    // A line address is held in at most one way of its set
    assert property (@(posedge clk) disable iff (!arst_n) $onehot0(hit))
        else $error("cache_datapath: line present in more than one way");

endmodule : cache_datapath

`default_nettype wire

// ==== hdl/cache_geometry_pkg.sv ====
`default_nettype none

package cache_geometry_pkg;

    // Cache organization
    localparam int num_sets       = 4;
    localparam int num_ways       = 2;
    localparam int line_addr_bits = 12;
    localparam int line_bytes     = 16;

    // Widths that follow from the organization
    localparam int set_bits  = $clog2(num_sets);
    localparam int way_bits  = $clog2(num_ways);
    localparam int tag_bits  = line_addr_bits - set_bits;
    localparam int line_bits = line_bytes * 8;

    typedef logic [set_bits-1:0]       set_idx_t;
    typedef logic [way_bits-1:0]       way_idx_t;
    typedef logic [tag_bits-1:0]       tag_t;
    typedef logic [line_addr_bits-1:0] line_addr_t;
    typedef logic [line_bits-1:0]      line_data_t;
    typedef logic [line_bytes-1:0]     byte_sel_t;

    // Recency rank of a way inside its set, 0 is the most recently used
    typedef logic [way_bits-1:0]       age_t;

endpackage : cache_geometry_pkg

`default_nettype wire

// ==== hdl/eviction_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module eviction_buffer
    import cache_geometry_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       evict_load,
    input  logic       evict_done,
    input  line_addr_t addr_in,
    input  line_data_t data_in,
    output line_addr_t addr_out,
    output line_data_t data_out,
    output logic       evict_pending
);

    always_ff @(posedge clk) begin
        if (evict_load) begin
            addr_out <= addr_in;
            data_out <= data_in;
        end
    end

    // Occupied from the victim capture until its write-back is acknowledged
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            evict_pending <= 1'b0;
        end else if (evict_load) begin
            evict_pending <= 1'b1;
        end else if (evict_done) begin
            evict_pending <= 1'b0;
        end
    end

    // Only one victim fits, so the controller must not evict into a full buffer
    assert property (@(posedge clk) disable iff (!arst_n) evict_load |-> !evict_pending)
        else $error("eviction_buffer: load while a victim is still pending");

    // A write-back can only complete for a victim that is actually held
    assert property (@(posedge clk) disable iff (!arst_n) evict_done |-> evict_pending)
        else $error("eviction_buffer: write-back done with an empty buffer");

endmodule : eviction_buffer

`default_nettype wire

// ==== hdl/eviction_buffered_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module eviction_buffered_cache
    import cache_geometry_pkg::*;
    import wishbone_pkg::*;
(
    input  logic     clk,
    input  logic     arst_n,
    input  cpu_req_t cpu_req,
    output cpu_rsp_t cpu_rsp,
    output mem_req_t mem_req,
    input  mem_rsp_t mem_rsp
);

    // Controller to datapath
    way_idx_t way_sel;
    logic     fill_sel;
    logic     tag_bypass_sel;
    logic     load;
    logic     load_age;

    // Datapath to controller
    logic [num_ways-1:0] hit;
    logic                dirty;
    way_idx_t            lru_way;

    logic       evict_load;
    logic       evict_done;
    logic       evict_pending;
    logic       wb_sel;
    logic       cpu_ack;
    logic       cpu_rty;
    logic       mem_cyc;
    logic       mem_stb;
    logic       mem_we;
    line_data_t cpu_rdata;
    line_addr_t fill_addr;
    line_addr_t victim_addr;
    line_data_t victim_data;
    line_addr_t evict_addr;
    line_data_t evict_data;
    line_addr_t mem_adr;
    line_data_t mem_dat;

    cache_datapath _cache_datapath (
        .clk,
        .arst_n,
        .cpu_req,
        .mem_rdata(mem_rsp.dat),
        .way_sel,
        .fill_sel,
        .tag_bypass_sel,
        .load,
        .load_age,
        .hit,
        .dirty,
        .lru_way,
        .cpu_rdata,
        .victim_addr,
        .victim_data,
        .fill_addr
    );

    eviction_buffer _eviction_buffer (
        .clk,
        .arst_n,
        .evict_load,
        .evict_done,
        .addr_in(victim_addr),
        .data_in(victim_data),
        .addr_out(evict_addr),
        .data_out(evict_data),
        .evict_pending
    );

    eviction_buffered_cache_controller _cache_controller (
        .clk,
        .arst_n,
        .cpu_req,
        .mem_rsp_ack(mem_rsp.ack),
        .mem_rsp_rty(mem_rsp.rty),
        .hit,
        .dirty,
        .lru_way,
        .evict_pending,
        .way_sel,
        .fill_sel,
        .tag_bypass_sel,
        .load,
        .load_age,
        .evict_load,
        .evict_done,
        .wb_sel,
        .cpu_ack,
        .cpu_rty,
        .mem_cyc,
        .mem_stb,
        .mem_we
    );

    // Fills use the request address, write-backs take address and line from the buffer
    assign mem_adr = wb_sel ? evict_addr : fill_addr;
    assign mem_dat = wb_sel ? evict_data : victim_data;

    assign mem_req = '{cyc: mem_cyc, stb: mem_stb, we: mem_we, adr: mem_adr, dat: mem_dat};
    assign cpu_rsp = '{ack: cpu_ack, rty: cpu_rty, dat: cpu_rdata};

endmodule : eviction_buffered_cache

`default_nettype wire

// ==== hdl/eviction_buffered_cache_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module eviction_buffered_cache_controller
    import cache_geometry_pkg::*;
    import wishbone_pkg::*;
(
    input  logic                clk,
    input  logic                arst_n,
    input  cpu_req_t            cpu_req,
    input  logic                mem_rsp_ack,
    input  logic                mem_rsp_rty,
    input  logic [num_ways-1:0] hit,
    input  logic                dirty,
    input  way_idx_t            lru_way,
    input  logic                evict_pending,
    output way_idx_t            way_sel,
    output logic                fill_sel,
    output logic                tag_bypass_sel,
    output logic                load,
    output logic                load_age,
    output logic                evict_load,
    output logic                evict_done,
    output logic                wb_sel,
    output logic                cpu_ack,
    output logic                cpu_rty,
    output logic                mem_cyc,
    output logic                mem_stb,
    output logic                mem_we
);

    typedef enum logic [2:0] {
        idle,
        lookup,
        evict,
        fill_req,
        fill_write,
        respond,
        writeback,
        retry_gap
    } state_e;

    // The CPU side sequence and the background write-back each keep their own state
    state_e   state_q;
    state_e   wb_state_q;
    way_idx_t hit_way;
    logic     wb_start;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    // The buffered victim goes out once the CPU has been answered for the fill.
    // evict_done is checked because pending only clears one cycle after it
    assign wb_start = (state_q == respond) && evict_pending && !evict_done &&
                      (wb_state_q == idle);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q        <= idle;
            wb_state_q     <= idle;
            way_sel        <= '0;
            fill_sel       <= 1'b0;
            tag_bypass_sel <= 1'b0;
            load           <= 1'b0;
            load_age       <= 1'b0;
            evict_load     <= 1'b0;
            evict_done     <= 1'b0;
            wb_sel         <= 1'b0;
            cpu_ack        <= 1'b0;
            cpu_rty        <= 1'b0;
            mem_cyc        <= 1'b0;
            mem_stb        <= 1'b0;
            mem_we         <= 1'b0;
        end else begin
            // Pulses last one cycle unless a state below raises them again
            load       <= 1'b0;
            load_age   <= 1'b0;
            evict_load <= 1'b0;
            evict_done <= 1'b0;
            cpu_ack    <= 1'b0;
            cpu_rty    <= 1'b0;

            case (state_q)
                idle: begin
                    if (cpu_req.cyc && cpu_req.stb) begin
                        state_q <= lookup;
                    end
                end
                lookup: begin
                    if (|hit) begin
                        state_q        <= respond;
                        way_sel        <= hit_way;
                        fill_sel       <= 1'b0;
                        tag_bypass_sel <= 1'b0;
                        load           <= cpu_req.we;
                        load_age       <= 1'b1;
                        cpu_ack        <= 1'b1;
                    end else if (evict_pending) begin
                        // Memory side is busy with the old victim
                        state_q <= respond;
                        cpu_rty <= 1'b1;
                    end else if (dirty) begin
                        state_q    <= evict;
                        way_sel    <= lru_way;
                        evict_load <= 1'b1;
                    end else begin
                        state_q <= fill_req;
                        way_sel <= lru_way;
                        wb_sel  <= 1'b0;
                        mem_cyc <= 1'b1;
                        mem_stb <= 1'b1;
                        mem_we  <= 1'b0;
                    end
                end
                evict: begin
                    state_q <= fill_req;
                    wb_sel  <= 1'b0;
                    mem_cyc <= 1'b1;
                    mem_stb <= 1'b1;
                    mem_we  <= 1'b0;
                end
                fill_req: begin
                    if (mem_rsp_ack) begin
                        state_q        <= fill_write;
                        mem_cyc        <= 1'b0;
                        mem_stb        <= 1'b0;
                        fill_sel       <= 1'b1;
                        tag_bypass_sel <= 1'b1;
                        load           <= 1'b1;
                    end else if (mem_rsp_rty) begin
                        state_q <= retry_gap;
                        mem_stb <= 1'b0;
                    end
                end
                retry_gap: begin
                    state_q <= fill_req;
                    mem_stb <= 1'b1;
                end
                fill_write: begin
                    // A write miss merges its bytes over the freshly filled line
                    state_q        <= respond;
                    fill_sel       <= 1'b0;
                    tag_bypass_sel <= 1'b0;
                    load           <= cpu_req.we;
                    load_age       <= 1'b1;
                    cpu_ack        <= 1'b1;
                end
                default: begin
                    state_q <= idle;
                end
            endcase

            case (wb_state_q)
                idle: begin
                    if (wb_start) begin
                        wb_state_q <= writeback;
                        wb_sel     <= 1'b1;
                        mem_cyc    <= 1'b1;
                        mem_stb    <= 1'b1;
                        mem_we     <= 1'b1;
                    end
                end
                writeback: begin
                    if (mem_rsp_ack) begin
                        wb_state_q <= idle;
                        mem_cyc    <= 1'b0;
                        mem_stb    <= 1'b0;
                        mem_we     <= 1'b0;
                        evict_done <= 1'b1;
                    end else if (mem_rsp_rty) begin
                        wb_state_q <= retry_gap;
                        mem_stb    <= 1'b0;
                    end
                end
                retry_gap: begin
                    wb_state_q <= writeback;
                    mem_stb    <= 1'b1;
                end
                default: begin
                    wb_state_q <= idle;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) !(cpu_ack && cpu_rty))
        else $error("controller: cpu ack and rty raised together");

    // A memory retry costs one cycle with the strobe down before the reissue
    assert property (@(posedge clk) disable iff (!arst_n)
                     (mem_stb && mem_rsp_rty) |=> !mem_stb)
        else $error("controller: mem stb held through a retry");

endmodule : eviction_buffered_cache_controller

`default_nettype wire

// ==== hdl/wishbone_pkg.sv ====
`default_nettype none

package wishbone_pkg;

    import cache_geometry_pkg::*;

    // CPU side request, held stable by the CPU until ack or rty
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        line_addr_t adr;
        byte_sel_t  sel;
        line_data_t dat;
    } cpu_req_t;

    typedef struct packed {
        logic       ack;
        logic       rty;
        line_data_t dat;
    } cpu_rsp_t;

    // Memory side transfers always move a whole line
    typedef struct packed {
        logic       cyc;
        logic       stb;
        logic       we;
        line_addr_t adr;
        line_data_t dat;
    } mem_req_t;

    typedef struct packed {
        logic       ack;
        logic       rty;
        line_data_t dat;
    } mem_rsp_t;

endpackage : wishbone_pkg

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
    --top-module tb_eviction_buffered_cache --Mdir obj_dir -o sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    // 4 ns period
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        #1 arst_n = 1'b1;
    end

endmodule : tb_clock_gen

`default_nettype wire

// ==== testbench/tb_eviction_buffered_cache.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_eviction_buffered_cache
    import cache_geometry_pkg::*;
    import wishbone_pkg::*;
();

    logic     clk;
    logic     arst_n;
    cpu_req_t cpu_req;
    cpu_rsp_t cpu_rsp;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    int       write_count;

    line_data_t  shadow [1 << line_addr_bits];
    logic [31:0] lfsr_state;
    int          stim_errors;
    int          mon_errors;
    int          accesses;
    int          cpu_retries;

    // Monitor state
    int         since_reset;
    int         wb_idle_cycles;
    logic       prev_wb_busy;
    logic       prev_ack;
    logic       prev_stb;
    logic       rty_pending;
    mem_req_t   rty_req;

    tb_clock_gen clock_gen (
        .clk,
        .arst_n
    );

    tb_memory_model mem_model (
        .clk,
        .mem_req,
        .mem_rsp,
        .write_count
    );

    eviction_buffered_cache dut (
        .clk,
        .arst_n,
        .cpu_req,
        .cpu_rsp,
        .mem_req,
        .mem_rsp
    );

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = next_lfsr(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    function automatic line_data_t line_pattern(input line_addr_t a);
        return {8{4'hc, a}};
    endfunction

    function automatic line_data_t merge_bytes(input line_data_t old, input line_data_t dat,
                                               input byte_sel_t sel);
        line_data_t res;
        res = old;
        for (int b = 0; b < line_bytes; b++) begin
            if (sel[b]) begin
                res[b*8 +: 8] = dat[b*8 +: 8];
            end
        end
        return res;
    endfunction

    task automatic show_mismatch(input string name, input logic [127:0] got,
                                 input logic [127:0] exp);
        $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
    endtask

    task automatic finish_run();
        $display("accesses %0d, cpu retries %0d, memory writes %0d, errors %0d",
                 accesses, cpu_retries, write_count, stim_errors + mon_errors);
        if (stim_errors + mon_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string why);
        stim_errors++;
        $display("ERROR at %0t: %s", $time, why);
    endtask

    // One CPU access, reissued after each rty until it is acknowledged
    task automatic run_access(input line_addr_t adr, input logic we, input byte_sel_t sel,
                              input line_data_t dat, input logic check_latency,
                              output logic ok);
        int   cycles;
        int   tries;
        logic done;
        tries = 0;
        done  = 1'b0;
        ok    = 1'b1;
        while (!done && ok) begin
            @(posedge clk);
            #1;
            cpu_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, sel: sel, dat: dat};
            cycles = 0;
            while (!cpu_rsp.ack && !cpu_rsp.rty && cycles < 300) begin
                @(posedge clk);
                #1;
                cycles++;
            end
            cpu_req.cyc = 1'b0;
            cpu_req.stb = 1'b0;
            if (!cpu_rsp.ack && !cpu_rsp.rty) begin
                report_timeout("no cpu ack or rty within 300 cycles");
                ok = 1'b0;
            end else if (cpu_rsp.ack) begin
                done = 1'b1;
                if (check_latency && tries == 0) begin
                    assert (cycles == 2) else begin
                        stim_errors++;
                        show_mismatch("cpu_rsp.ack latency", 128'(cycles), 128'd2);
                    end
                end
                if (we) begin
                    shadow[adr] = merge_bytes(shadow[adr], dat, sel);
                end else begin
                    assert (cpu_rsp.dat === shadow[adr]) else begin
                        stim_errors++;
                        show_mismatch("cpu_rsp.dat", cpu_rsp.dat, shadow[adr]);
                    end
                end
            end else begin
                // A retry is only expected while the victim write-back is still out
                assert (wb_idle_cycles <= 3) else begin
                    stim_errors++;
                    $display("ERROR at %0t: cpu rty without an outstanding write-back", $time);
                end
                cpu_retries++;
                tries++;
                if (tries >= 50) begin
                    report_timeout("access was retried too often");
                    ok = 1'b0;
                end
            end
        end
        accesses++;
    endtask

    initial begin
        line_addr_t  adr;
        logic        we;
        byte_sel_t   sel;
        line_data_t  dat;
        logic [31:0] r;
        int          cnt;
        logic        ok;
        cpu_req     = '0;
        lfsr_state  = 32'h520b_270e;
        stim_errors = 0;
        accesses    = 0;
        cpu_retries = 0;
        for (int a = 0; a < (1 << line_addr_bits); a++) begin
            shadow[a] = line_pattern(line_addr_t'(a));
        end
        ok  = 1'b1;
        cnt = 0;
        while (!arst_n && cnt < 50) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (!arst_n) begin
            report_timeout("reset was never released");
            ok = 1'b0;
        end
        for (int n = 0; n < 400 && ok; n++) begin
            // Four tags over four sets keep the two ways under pressure
            draw_bits(4, r);
            adr = {r[3:2], 8'h3a, r[1:0]};
            draw_bits(1, r);
            we = r[0];
            draw_bits(16, r);
            sel = r[15:0];
            draw_bits(32, r);
            dat = {r, ~r, r ^ 32'h5a5a_5a5a, r + 32'd1};
            run_access(adr, we, sel, dat, 1'b0, ok);
            draw_bits(1, r);
            if (ok && r[0]) begin
                run_access(adr, 1'b0, '0, '0, 1'b1, ok);
            end
        end
        finish_run();
    end

    // Bus monitor sampled at the falling edge, where every signal is settled
    always @(negedge clk) begin
        if (!arst_n) begin
            since_reset    = 0;
            mon_errors     = 0;
            wb_idle_cycles = 100;
            prev_wb_busy   = 1'b0;
            prev_ack       = 1'b0;
            prev_stb       = 1'b0;
            rty_pending    = 1'b0;
        end else if (since_reset < 4) begin
            since_reset++;
        end
        if (!arst_n || since_reset < 2) begin
            assert (!cpu_rsp.ack && !cpu_rsp.rty && !mem_req.cyc && !mem_req.stb) else begin
                mon_errors++;
                $display("ERROR at %0t: bus strobe active during or right after reset", $time);
            end
        end
        if (arst_n) begin
            assert (!(cpu_rsp.ack && cpu_rsp.rty)) else begin
                mon_errors++;
                $display("ERROR at %0t: cpu ack and rty high in the same cycle", $time);
            end
            if (mem_req.cyc && mem_req.we) begin
                wb_idle_cycles = 0;
                // The write-back begins the cycle after the cpu ack of the displacing miss
                if (!prev_wb_busy) begin
                    assert (prev_ack) else begin
                        mon_errors++;
                        $display("ERROR at %0t: write-back started without a cpu ack", $time);
                    end
                end
            end else if (wb_idle_cycles < 100) begin
                wb_idle_cycles++;
            end
            if (mem_req.cyc && mem_req.stb && mem_req.we && mem_rsp.ack) begin
                assert (mem_req.dat === shadow[mem_req.adr]) else begin
                    mon_errors++;
                    show_mismatch("mem_req.dat", mem_req.dat, shadow[mem_req.adr]);
                end
            end
            if (mem_req.stb && !prev_stb && rty_pending) begin
                rty_pending = 1'b0;
                assert (mem_req.we === rty_req.we) else begin
                    mon_errors++;
                    show_mismatch("mem_req.we", 128'(mem_req.we), 128'(rty_req.we));
                end
                assert (mem_req.adr === rty_req.adr) else begin
                    mon_errors++;
                    show_mismatch("mem_req.adr", 128'(mem_req.adr), 128'(rty_req.adr));
                end
                assert (mem_req.dat === rty_req.dat) else begin
                    mon_errors++;
                    show_mismatch("mem_req.dat", mem_req.dat, rty_req.dat);
                end
            end
            if (mem_req.stb && mem_rsp.rty) begin
                rty_pending = 1'b1;
                rty_req     = mem_req;
            end
            prev_wb_busy = mem_req.cyc && mem_req.we;
            prev_ack     = cpu_rsp.ack;
            prev_stb     = mem_req.stb;
        end
    end

endmodule : tb_eviction_buffered_cache

`default_nettype wire

// ==== testbench/tb_memory_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_memory_model
    import cache_geometry_pkg::*;
    import wishbone_pkg::*;
(
    input  logic     clk,
    input  mem_req_t mem_req,
    output mem_rsp_t mem_rsp,
    output int       write_count
);

    line_data_t  backing [1 << line_addr_bits];
    logic [31:0] lfsr_state;
    logic [31:0] wait_cnt;
    logic [31:0] r;
    logic        active;

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = next_lfsr(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Every line starts with a pattern built from its whole address
    function automatic line_data_t line_pattern(input line_addr_t a);
        return {8{4'hc, a}};
    endfunction

    initial begin
        for (int a = 0; a < (1 << line_addr_bits); a++) begin
            backing[a] = line_pattern(line_addr_t'(a));
        end
        lfsr_state  = 32'h520b_270e;
        mem_rsp     = '0;
        write_count = 0;
        active      = 1'b0;
        wait_cnt    = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_rsp.ack = 1'b0;
            mem_rsp.rty = 1'b0;
            if (mem_req.cyc && mem_req.stb) begin
                if (!active) begin
                    active = 1'b1;
                    draw_bits(2, wait_cnt);
                end else if (wait_cnt != 0) begin
                    wait_cnt = wait_cnt - 1;
                end
                if (active && wait_cnt == 0) begin
                    active = 1'b0;
                    draw_bits(3, r);
                    // About one transfer in eight is turned away
                    if (r == 0) begin
                        mem_rsp.rty = 1'b1;
                    end else begin
                        mem_rsp.ack = 1'b1;
                        if (mem_req.we) begin
                            backing[mem_req.adr] = mem_req.dat;
                            write_count = write_count + 1;
                        end else begin
                            mem_rsp.dat = backing[mem_req.adr];
                        end
                    end
                end
            end
        end
    end

endmodule : tb_memory_model

`default_nettype wire
